//--- mem_test_params.svh
`ifndef MEM_TEST_PARAMS_SVH
`define MEM_TEST_PARAMS_SVH

// application port widths of the DDR3 controller user side
`define MT_APP_ADDR_WIDTH 28
`define MT_APP_DATA_WIDTH 256

`define MT_ADDR_STEP      256     // address increment per beat
`define MT_SWEEP_BEATS    1048576 // 2**20 beats per sweep
`define MT_COUNT_WIDTH    32

// pattern at reset, most significant word first
`define MT_INIT_PATTERN { \
   32'hcafe_babe, \
   32'h1234_5678, \
   32'haa55_aa55, \
   32'h55aa_55aa, \
   32'hdead_beef, \
   32'h8765_4321, \
   32'h55aa_55aa, \
   32'haa55_aa55  \
}

`endif

//--- mem_test_pkg.sv
`include "mem_test_params.svh"

package mem_test_pkg;

   // opcodes as seen on app_cmd
   typedef enum logic [2:0] {
      app_cmd_write = 3'b000,
      app_cmd_read  = 3'b001
   } app_cmd_e;

   typedef enum logic [2:0] {
      st_idle       = 3'd0,
      st_write      = 3'd1,
      st_write_done = 3'd2,
      st_read       = 3'd3,
      st_read_done  = 3'd4,
      st_check      = 3'd5,
      st_park       = 3'd6
   } test_state_e;

   // command channel: app_en, app_cmd, app_addr
   typedef struct packed {
      logic                          en;
      app_cmd_e                      cmd;
      logic [`MT_APP_ADDR_WIDTH-1:0] addr;
   } app_req_t;

   // write data channel: app_wdf_wren, app_wdf_data
   typedef struct packed {
      logic                          wren;
      logic [`MT_APP_DATA_WIDTH-1:0] data;
   } app_wdata_t;

   // read data channel: app_rd_data_valid, app_rd_data
   typedef struct packed {
      logic                          valid;
      logic [`MT_APP_DATA_WIDTH-1:0] data;
   } app_rdata_t;

endpackage

//--- pattern_source.sv
`include "mem_test_params.svh"

module pattern_source #(
   parameter int sweep_beats = `MT_SWEEP_BEATS
) (
   input  logic                          ui_clk,
   input  logic                          resetn,
   input  logic                          advance,
   output logic [`MT_APP_DATA_WIDTH-1:0] pattern,
   output logic [`MT_APP_ADDR_WIDTH-1:0] addr,
   output logic                          sweep_start
);

   localparam int idx_w = (sweep_beats > 1) ? $clog2(sweep_beats) : 1;
   localparam logic [idx_w-1:0] last_idx = idx_w'(sweep_beats - 1);

   logic [idx_w-1:0] beat_idx;

   always_ff @(posedge ui_clk or negedge resetn) begin
      if (!resetn) begin
         pattern <= `MT_INIT_PATTERN;
      end else if (advance) begin
         // rotate left by one byte
         pattern <= {pattern[`MT_APP_DATA_WIDTH-9:0],
                     pattern[`MT_APP_DATA_WIDTH-1 -: 8]};
      end
   end

   always_ff @(posedge ui_clk or negedge resetn) begin
      if (!resetn) begin
         beat_idx <= '0;
      end else if (advance) begin
         if (beat_idx == last_idx) begin
            beat_idx <= '0; // end of sweep
         end else begin
            beat_idx <= beat_idx + 1'b1;
         end
      end
   end

   // byte address of the current beat
   assign addr = `MT_APP_ADDR_WIDTH'(beat_idx) * `MT_APP_ADDR_WIDTH'(`MT_ADDR_STEP);

   assign sweep_start = (beat_idx == '0);

endmodule

//--- test_sequencer.sv
`include "mem_test_params.svh"

module test_sequencer (
   input  logic                          ui_clk,
   input  logic                          resetn,
   input  logic                          calib_done,
   input  logic                          app_rdy,
   input  logic                          app_wdf_rdy,
   input  logic                          rd_valid,
   input  logic [`MT_APP_DATA_WIDTH-1:0] pattern,
   input  logic [`MT_APP_ADDR_WIDTH-1:0] addr,
   input  logic                          verdict_pass,
   input  logic                          verdict_fail,
   output mem_test_pkg::app_req_t        app_req,
   output mem_test_pkg::app_wdata_t      app_wdata,
   output logic                          advance
);

   import mem_test_pkg::*;

   test_state_e                   state;
   logic                          wren_q;
   logic [`MT_APP_DATA_WIDTH-1:0] wdata_q;

   always_ff @(posedge ui_clk or negedge resetn) begin
      if (!resetn) begin
         state   <= st_idle;
         app_req <= '{en: 1'b0, cmd: app_cmd_write, addr: '0};
         wren_q  <= 1'b0;
      end else begin
         case (state)
            st_idle: begin
               if (calib_done) begin
                  state <= st_write;
               end
            end

            st_write: begin
               // command and data go out together
               if (app_rdy && app_wdf_rdy) begin
                  app_req.en   <= 1'b1;
                  app_req.cmd  <= app_cmd_write;
                  app_req.addr <= addr;
                  wren_q       <= 1'b1;
                  state        <= st_write_done;
               end
            end

            st_write_done: begin
               if (app_req.en && app_rdy) begin
                  app_req.en <= 1'b0; // command taken
               end
               if (wren_q && app_wdf_rdy) begin
                  wren_q <= 1'b0; // data taken
               end
               if (!app_req.en && !wren_q) begin
                  state <= st_read;
               end
            end

            st_read: begin
               if (app_rdy) begin
                  app_req.en   <= 1'b1;
                  app_req.cmd  <= app_cmd_read;
                  app_req.addr <= addr;
                  state        <= st_read_done;
               end
            end

            st_read_done: begin
               if (app_req.en && app_rdy) begin
                  app_req.en <= 1'b0;
               end
               if (rd_valid) begin
                  state <= st_check;
               end
            end

            st_check: begin
               // verdict arrives one cycle after capture
               if (verdict_fail) begin
                  state <= st_park;
               end else if (verdict_pass) begin
                  state <= st_write;
               end
            end

            st_park: begin
               state <= st_park; // held until reset
            end

            default: begin
               state <= st_idle;
            end
         endcase
      end
   end

   // write payload, loaded with the command
   always_ff @(posedge ui_clk) begin
      if (state == st_write && app_rdy && app_wdf_rdy) begin
         wdata_q <= pattern;
      end
   end

   assign app_wdata = '{wren: wren_q, data: wdata_q};

   assign advance = (state == st_check) && verdict_pass && !verdict_fail;

endmodule

//--- result_checker.sv
`include "mem_test_params.svh"

module result_checker (
   input  logic                          ui_clk,
   input  logic                          resetn,
   input  mem_test_pkg::app_rdata_t      app_rd,
   input  logic [`MT_APP_DATA_WIDTH-1:0] pattern,
   input  logic                          sweep_start,
   output logic                          verdict_pass,
   output logic                          verdict_fail,
   output logic                          led_pass,
   output logic                          led_fail,
   output logic [`MT_COUNT_WIDTH-1:0]    sweep_count
);

   logic                          rd_hit;
   logic [`MT_APP_DATA_WIDTH-1:0] rd_data_q;
   logic [`MT_APP_DATA_WIDTH-1:0] expect_q;
   logic                          match;

   // capture the beat and what it should be
   always_ff @(posedge ui_clk) begin
      if (app_rd.valid) begin
         rd_data_q <= app_rd.data;
         expect_q  <= pattern;
      end
   end

   assign match = (rd_data_q == expect_q);

   always_ff @(posedge ui_clk or negedge resetn) begin
      if (!resetn) begin
         rd_hit       <= 1'b0;
         verdict_pass <= 1'b0;
         verdict_fail <= 1'b0;
      end else begin
         rd_hit       <= app_rd.valid;
         verdict_pass <= rd_hit && match;
         verdict_fail <= rd_hit && !match;
      end
   end

   always_ff @(posedge ui_clk or negedge resetn) begin
      if (!resetn) begin
         led_pass    <= 1'b0;
         sweep_count <= '0;
      end else if (rd_hit && match && sweep_start) begin
         // first beat of a sweep passed
         led_pass    <= ~led_pass;
         sweep_count <= sweep_count + 1'b1;
      end
   end

   always_ff @(posedge ui_clk or negedge resetn) begin
      if (!resetn) begin
         led_fail <= 1'b0;
      end else if (rd_hit && !match) begin
         led_fail <= 1'b1; // sticky
      end
   end

endmodule

//--- mem_tester_top.sv
`include "mem_test_params.svh"

module mem_tester_top #(
   parameter int sweep_beats = `MT_SWEEP_BEATS
) (
   input  logic                          ui_clk,
   input  logic                          resetn,
   input  logic                          calib_done,
   input  logic                          app_rdy,
   input  logic                          app_wdf_rdy,
   input  mem_test_pkg::app_rdata_t      app_rd,
   output mem_test_pkg::app_req_t        app_req,
   output mem_test_pkg::app_wdata_t      app_wdata,
   output logic                          led_pass,
   output logic                          led_fail,
   output logic                          led_calib,
   output logic [`MT_COUNT_WIDTH-1:0]    sweep_count
);

   logic [`MT_APP_DATA_WIDTH-1:0] pattern;
   logic [`MT_APP_ADDR_WIDTH-1:0] addr;
   logic                          sweep_start;
   logic                          advance;
   logic                          verdict_pass;
   logic                          verdict_fail;

   pattern_source #(
      .sweep_beats (sweep_beats)
   ) u_pattern_source (
      .ui_clk      (ui_clk),
      .resetn      (resetn),
      .advance     (advance),
      .pattern     (pattern),
      .addr        (addr),
      .sweep_start (sweep_start)
   );

   test_sequencer u_test_sequencer (
      .ui_clk       (ui_clk),
      .resetn       (resetn),
      .calib_done   (calib_done),
      .app_rdy      (app_rdy),
      .app_wdf_rdy  (app_wdf_rdy),
      .rd_valid     (app_rd.valid),
      .pattern      (pattern),
      .addr         (addr),
      .verdict_pass (verdict_pass),
      .verdict_fail (verdict_fail),
      .app_req      (app_req),
      .app_wdata    (app_wdata),
      .advance      (advance)
   );

   result_checker u_result_checker (
      .ui_clk       (ui_clk),
      .resetn       (resetn),
      .app_rd       (app_rd),
      .pattern      (pattern),
      .sweep_start  (sweep_start),
      .verdict_pass (verdict_pass),
      .verdict_fail (verdict_fail),
      .led_pass     (led_pass),
      .led_fail     (led_fail),
      .sweep_count  (sweep_count)
   );

   assign led_calib = calib_done; // straight from the controller

endmodule

//--- mig_app_model.sv
`include "mem_test_params.svh"

module mig_app_model (
   input  logic                          ui_clk,
   input  logic                          resetn,
   input  logic [31:0]                   rnd,
   input  logic                          fault_inject,
   input  mem_test_pkg::app_req_t        app_req,
   input  mem_test_pkg::app_wdata_t      app_wdata,
   output logic                          app_rdy,
   output logic                          app_wdf_rdy,
   output mem_test_pkg::app_rdata_t      app_rd,
   output logic                          wr_done,
   output logic [`MT_APP_ADDR_WIDTH-1:0] wr_addr,
   output logic [`MT_APP_DATA_WIDTH-1:0] wr_data,
   output logic                          rd_pending
);

   timeunit 1ns;
   timeprecision 1ps;

   import mem_test_pkg::*;

   logic [`MT_APP_DATA_WIDTH-1:0] mem [logic [`MT_APP_ADDR_WIDTH-1:0]];
   logic                          have_cmd;
   logic                          have_data;
   logic [`MT_APP_ADDR_WIDTH-1:0] cmd_addr;
   logic [`MT_APP_DATA_WIDTH-1:0] data_q;
   logic [`MT_APP_ADDR_WIDTH-1:0] rd_addr;
   logic [3:0]                    rd_wait;
   logic [`MT_APP_DATA_WIDTH-1:0] rd_flip;

   initial begin
      app_rdy     = 1'b0;
      app_wdf_rdy = 1'b0;
      app_rd      = '0;
      wr_done     = 1'b0;
      rd_pending  = 1'b0;
   end

   // upper LCG bits, about one cycle in four stalled on each ready
   always @(posedge ui_clk or negedge resetn) begin
      if (!resetn) begin
         app_rdy     <= 1'b0;
         app_wdf_rdy <= 1'b0;
      end else begin
         app_rdy     <= (rnd[31:30] != 2'b00);
         app_wdf_rdy <= (rnd[29:28] != 2'b00);
      end
   end

   // a write lands once both command and data are taken
   always @(posedge ui_clk or negedge resetn) begin : write_path
      logic                          cmd_hit;
      logic                          data_hit;
      logic [`MT_APP_ADDR_WIDTH-1:0] addr_now;
      logic [`MT_APP_DATA_WIDTH-1:0] data_now;
      if (!resetn) begin
         have_cmd  <= 1'b0;
         have_data <= 1'b0;
         wr_done   <= 1'b0;
      end else begin
         cmd_hit  = app_req.en && app_rdy && (app_req.cmd == app_cmd_write);
         data_hit = app_wdata.wren && app_wdf_rdy;
         addr_now = cmd_hit ? app_req.addr : cmd_addr;
         data_now = data_hit ? app_wdata.data : data_q;
         wr_done  <= 1'b0;
         if ((have_cmd || cmd_hit) && (have_data || data_hit)) begin
            mem[addr_now] = data_now;
            wr_done   <= 1'b1;
            wr_addr   <= addr_now;
            wr_data   <= data_now;
            have_cmd  <= 1'b0;
            have_data <= 1'b0;
         end else begin
            have_cmd  <= have_cmd || cmd_hit;
            have_data <= have_data || data_hit;
            cmd_addr  <= addr_now;
            data_q    <= data_now;
         end
      end
   end

   // read latency of 2 to 9 cycles after the command is taken
   always @(posedge ui_clk or negedge resetn) begin : read_path
      if (!resetn) begin
         rd_pending <= 1'b0;
         rd_wait    <= '0;
         rd_addr    <= '0;
         rd_flip    <= '0;
         app_rd     <= '0;
      end else begin
         app_rd.valid <= 1'b0;
         if (app_req.en && app_rdy && (app_req.cmd == app_cmd_read)) begin
            rd_pending <= 1'b1;
            rd_addr    <= app_req.addr;
            rd_wait    <= 4'(1 + rnd[27:25]);
            rd_flip    <= '0;
            if (fault_inject) begin
               rd_flip[rnd[23:16]] <= 1'b1; // one corrupted bit
            end
         end else if (rd_pending) begin
            if (rd_wait == 0) begin
               app_rd.valid <= 1'b1;
               app_rd.data  <= (mem.exists(rd_addr) ? mem[rd_addr] : '0) ^ rd_flip;
               rd_pending   <= 1'b0;
            end else begin
               rd_wait <= rd_wait - 1'b1;
            end
         end
      end
   end

endmodule

//--- tb_mem_tester.sv
`include "mem_test_params.svh"

module tb_mem_tester;

   timeunit 1ns;
   timeprecision 1ps;

   import mem_test_pkg::*;

   localparam int tb_sweep_beats  = 4;
   localparam int clean_beats     = 12;
   localparam int clk_period      = 40;
   localparam int max_beats       = clean_beats + 2;
   localparam int beat_cycles_max = 64;  // stalls plus 9 cycle read latency
   localparam int extra_cycles    = 400; // reset, calibration, fault tail
   localparam longint watchdog_ns =
      longint'(max_beats * beat_cycles_max + extra_cycles) * clk_period;

   logic                          ui_clk;
   logic                          resetn;
   logic                          calib_done;
   logic                          fault_inject;
   logic [31:0]                   rnd;
   logic                          app_rdy;
   logic                          app_wdf_rdy;
   app_rdata_t                    app_rd;
   app_req_t                      app_req;
   app_wdata_t                    app_wdata;
   logic                          led_pass;
   logic                          led_fail;
   logic                          led_calib;
   logic [`MT_COUNT_WIDTH-1:0]    sweep_count;
   logic                          wr_done;
   logic [`MT_APP_ADDR_WIDTH-1:0] wr_addr;
   logic [`MT_APP_DATA_WIDTH-1:0] wr_data;
   logic                          rd_pending;
   int                            wr_count;
   logic [`MT_APP_DATA_WIDTH-1:0] exp_data;

   function automatic logic [31:0] lcg_next(input logic [31:0] s);
      return s * 32'd1664525 + 32'd1013904223;
   endfunction

   function automatic logic [`MT_APP_DATA_WIDTH-1:0] rotl_byte(
      input logic [`MT_APP_DATA_WIDTH-1:0] v);
      return (v << 8) | (v >> (`MT_APP_DATA_WIDTH - 8));
   endfunction

   function automatic logic [`MT_APP_ADDR_WIDTH-1:0] beat_addr(input int n);
      return `MT_APP_ADDR_WIDTH'((n % tb_sweep_beats) * `MT_ADDR_STEP);
   endfunction

   task automatic abort_run();
      $display("TEST FAIL");
      $fatal(1, "stopped at the first error");
   endtask

   mem_tester_top #(
      .sweep_beats (tb_sweep_beats)
   ) dut0 (
      .ui_clk      (ui_clk),
      .resetn      (resetn),
      .calib_done  (calib_done),
      .app_rdy     (app_rdy),
      .app_wdf_rdy (app_wdf_rdy),
      .app_rd      (app_rd),
      .app_req     (app_req),
      .app_wdata   (app_wdata),
      .led_pass    (led_pass),
      .led_fail    (led_fail),
      .led_calib   (led_calib),
      .sweep_count (sweep_count)
   );

   mig_app_model u_mig_app_model (
      .ui_clk       (ui_clk),
      .resetn       (resetn),
      .rnd          (rnd),
      .fault_inject (fault_inject),
      .app_req      (app_req),
      .app_wdata    (app_wdata),
      .app_rdy      (app_rdy),
      .app_wdf_rdy  (app_wdf_rdy),
      .app_rd       (app_rd),
      .wr_done      (wr_done),
      .wr_addr      (wr_addr),
      .wr_data      (wr_data),
      .rd_pending   (rd_pending)
   );

   initial begin
      ui_clk = 1'b0;
      forever #(clk_period / 2) ui_clk = ~ui_clk;
   end

   always @(posedge ui_clk) rnd <= lcg_next(rnd);

   // reference steps on each completed write
   always @(posedge ui_clk) begin
      if (wr_done) begin
         wr_count <= wr_count + 1;
         exp_data <= rotl_byte(exp_data);
      end
   end

   quiet_before_calib: assert property (@(posedge ui_clk) disable iff (!resetn)
      !calib_done |-> !app_req.en && !app_wdata.wren)
      else begin
         $display("a strobe was raised before calibration finished at %0t", $time);
         abort_run();
      end

   calib_led_follows: assert property (@(posedge ui_clk) led_calib == calib_done)
      else begin
         $display("FAILED at %0t: led_calib expected %b, got %b", $time,
                  $sampled(calib_done), $sampled(led_calib));
         abort_run();
      end

   cmd_held_until_rdy: assert property (@(posedge ui_clk) disable iff (!resetn)
      app_req.en && !app_rdy |=> app_req.en && $stable(app_req))
      else begin
         $display("command dropped or changed before app_rdy at %0t", $time);
         abort_run();
      end

   wdata_held_until_rdy: assert property (@(posedge ui_clk) disable iff (!resetn)
      app_wdata.wren && !app_wdf_rdy |=> app_wdata.wren && $stable(app_wdata))
      else begin
         $display("write data dropped or changed before app_wdf_rdy at %0t", $time);
         abort_run();
      end

   single_read: assert property (@(posedge ui_clk) disable iff (!resetn)
      app_req.en && app_rdy && app_req.cmd == app_cmd_read |-> !rd_pending)
      else begin
         $display("a second read was issued while one was outstanding at %0t", $time);
         abort_run();
      end

   write_addr_ok: assert property (@(posedge ui_clk) disable iff (!resetn)
      wr_done |-> wr_addr == beat_addr(wr_count))
      else begin
         $display("FAILED at %0t: app_req.addr expected %h, got %h", $time,
                  beat_addr($sampled(wr_count)), $sampled(wr_addr));
         abort_run();
      end

   write_data_ok: assert property (@(posedge ui_clk) disable iff (!resetn)
      wr_done |-> wr_data == exp_data)
      else begin
         $display("FAILED at %0t: app_wdata.data expected %h, got %h", $time,
                  $sampled(exp_data), $sampled(wr_data));
         abort_run();
      end

   // beat 0 of a sweep is checked only after its own write completed
   count_tracks_sweeps: assert property (@(posedge ui_clk) disable iff (!resetn)
      $changed(sweep_count) |->
         sweep_count == (wr_count + tb_sweep_beats - 1) / tb_sweep_beats)
      else begin
         $display("FAILED at %0t: sweep_count expected %0d, got %0d", $time,
                  ($sampled(wr_count) + tb_sweep_beats - 1) / tb_sweep_beats,
                  $sampled(sweep_count));
         abort_run();
      end

   pass_led_with_count: assert property (@(posedge ui_clk) disable iff (!resetn)
      $changed(sweep_count) == $changed(led_pass))
      else begin
         $display("led_pass and sweep_count did not change together at %0t", $time);
         abort_run();
      end

   no_fail_when_clean: assert property (@(posedge ui_clk) disable iff (!resetn)
      !fault_inject |-> !led_fail)
      else begin
         $display("led_fail rose without an injected fault at %0t", $time);
         abort_run();
      end

   fail_led_sticky: assert property (@(posedge ui_clk) disable iff (!resetn)
      led_fail |=> led_fail && $stable(sweep_count))
      else begin
         $display("led_fail fell or sweep_count moved after a failure at %0t", $time);
         abort_run();
      end

   parked_after_fail: assert property (@(posedge ui_clk) disable iff (!resetn)
      led_fail |-> !app_req.en && !app_wdata.wren)
      else begin
         $display("a command was issued after the tester failed at %0t", $time);
         abort_run();
      end

   initial begin : watchdog
      #(watchdog_ns);
      $display("timeout: the run did not finish within %0d ns", watchdog_ns);
      abort_run();
   end

   initial begin : main_flow
      resetn       = 1'b0;
      calib_done   = 1'b0;
      fault_inject = 1'b0;
      rnd          = 32'hb7f5_8075;
      wr_count     = 0;
      exp_data     = `MT_INIT_PATTERN;
      repeat (10) @(posedge ui_clk);
      resetn <= 1'b1;
      repeat (6) @(posedge ui_clk);
      calib_done <= 1'b1;
      // the 13th write follows 12 passed beats
      while (wr_count < clean_beats + 1) @(posedge ui_clk);
      sweeps_after_clean: assert (sweep_count == clean_beats / tb_sweep_beats)
         else begin
            $display("FAILED at %0t: sweep_count expected %0d, got %0d", $time,
                     clean_beats / tb_sweep_beats, sweep_count);
            abort_run();
         end
      fault_inject <= 1'b1;
      while (!led_fail) @(posedge ui_clk);
      repeat (40) @(posedge ui_clk);
      $display("TEST PASS");
      $finish;
   end

endmodule

//--- files.f
+incdir+.
mem_test_pkg.sv
pattern_source.sv
test_sequencer.sv
result_checker.sv
mem_tester_top.sv
mig_app_model.sv
tb_mem_tester.sv

//--- Bender.yml
package:
  name: mem_tester

export_include_dirs:
  - .

sources:
  - files:
      - mem_test_pkg.sv
      - pattern_source.sv
      - test_sequencer.sv
      - result_checker.sv
      - mem_tester_top.sv
  - target: test
    files:
      - mig_app_model.sv
      - tb_mem_tester.sv
